//--- hdl/matmul_scheduler.sv
`timescale 1ns/1ps

module matmul_scheduler (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [sched_pkg::WB_AW-1:0] wb_adr_i,
  input  logic [sched_pkg::WB_DW-1:0] wb_dat_i,
  output logic [sched_pkg::WB_DW-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  input  logic                        x_valid_i,
  input  logic                        w_valid_i,
  input  sched_pkg::x_buf_flags_t     x_flags_i,
  input  sched_pkg::z_buf_flags_t     z_flags_i,
  output sched_pkg::x_buf_ctrl_t      x_ctrl_o,
  output sched_pkg::w_buf_ctrl_t      w_ctrl_o,
  output sched_pkg::z_buf_ctrl_t      z_ctrl_o,
  output sched_pkg::engine_ctrl_t     engine_o,
  output logic                        reg_enable_o
);

  sched_pkg::sched_cfg_t  cfg;
  sched_pkg::sched_step_t step;
  logic                   start;
  logic                   soft_clear;
  logic                   busy;
  logic                   w_done;
  logic                   w_col_done;
  logic                   x_full_check;
  logic                   y_check;

  sched_cfg_regs u_cfg_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .busy_i       (busy),
    .w_done_i     (w_done),
    .cfg_o        (cfg),
    .start_o      (start),
    .soft_clear_o (soft_clear)
  );

  sched_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (soft_clear),
    .start_i        (start),
    .cfg_i          (cfg),
    .w_valid_i      (w_valid_i),
    .x_flags_i      (x_flags_i),
    .z_flags_i      (z_flags_i),
    .x_full_check_i (x_full_check),
    .y_check_i      (y_check),
    .w_done_i       (w_done),
    .step_o         (step),
    .busy_o         (busy),
    .reg_enable_o   (reg_enable_o)
  );

  x_tile_seq u_x_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (soft_clear),
    .cfg_i          (cfg),
    .step_i         (step),
    .x_valid_i      (x_valid_i),
    .x_flags_i      (x_flags_i),
    .x_ctrl_o       (x_ctrl_o),
    .x_full_check_o (x_full_check)
  );

  w_tile_seq u_w_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (soft_clear),
    .cfg_i        (cfg),
    .step_i       (step),
    .w_ctrl_o     (w_ctrl_o),
    .w_col_done_o (w_col_done),
    .w_done_o     (w_done)
  );

  z_tile_seq u_z_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (soft_clear),
    .cfg_i        (cfg),
    .step_i       (step),
    .w_col_done_i (w_col_done),
    .z_flags_i    (z_flags_i),
    .z_ctrl_o     (z_ctrl_o),
    .engine_o     (engine_o),
    .y_check_o    (y_check)
  );

endmodule

//--- hdl/sched_cfg_regs.sv
`timescale 1ns/1ps

module sched_cfg_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [sched_pkg::WB_AW-1:0] wb_adr_i,
  input  logic [sched_pkg::WB_DW-1:0] wb_dat_i,
  output logic [sched_pkg::WB_DW-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  input  logic                        busy_i,
  input  logic                        w_done_i,
  output sched_pkg::sched_cfg_t       cfg_o,
  output logic                        start_o,
  output logic                        soft_clear_o
);

  sched_pkg::sched_reg_e       addr;
  sched_pkg::sched_cfg_t       cfg_q;
  logic [sched_pkg::WB_DW-1:0] rdata;
  logic [sched_pkg::WB_DW-1:0] rdata_q;
  logic                        ack_q;
  logic                        req;
  logic                        wr;
  logic                        start_q;
  logic                        clear_q;

  // A new access is taken only while no ack is pending, so each ack lasts one cycle
  assign req  = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr   = req && wb_we_i;
  assign addr = sched_pkg::sched_reg_e'(wb_adr_i);

  always_comb begin
    rdata = '0;
    case (addr)
      sched_pkg::REG_X_ITERS: rdata = {cfg_q.x_row_iters, cfg_q.x_col_iters};
      sched_pkg::REG_W_ITERS: rdata = {cfg_q.w_row_iters, cfg_q.w_col_iters};
      sched_pkg::REG_OP_SEL:  rdata[0] = cfg_q.y_required;
      sched_pkg::REG_STATUS:  rdata[1:0] = {w_done_i, busy_i};
      default:                rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      clear_q <= 1'b0;
      cfg_q   <= '0;
    end else begin
      ack_q   <= req;
      // Control bits are self-clearing and only produce pulses
      start_q <= wr && (addr == sched_pkg::REG_CTRL) && wb_dat_i[0];
      clear_q <= wr && (addr == sched_pkg::REG_CTRL) && wb_dat_i[1];
      if (wr) begin
        case (addr)
          sched_pkg::REG_X_ITERS: {cfg_q.x_row_iters, cfg_q.x_col_iters} <= wb_dat_i;
          sched_pkg::REG_W_ITERS: {cfg_q.w_row_iters, cfg_q.w_col_iters} <= wb_dat_i;
          sched_pkg::REG_OP_SEL:  cfg_q.y_required <= wb_dat_i[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && !wb_we_i)
      rdata_q <= rdata;
  end

  assign wb_ack_o     = ack_q;
  assign wb_dat_o     = rdata_q;
  assign cfg_o        = cfg_q;
  assign start_o      = start_q;
  assign soft_clear_o = clear_q;

endmodule

//--- hdl/sched_fsm.sv
`timescale 1ns/1ps

module sched_fsm (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    start_i,
  input  sched_pkg::sched_cfg_t   cfg_i,
  input  logic                    w_valid_i,
  input  sched_pkg::x_buf_flags_t x_flags_i,
  input  sched_pkg::z_buf_flags_t z_flags_i,
  input  logic                    x_full_check_i,
  input  logic                    y_check_i,
  input  logic                    w_done_i,
  output sched_pkg::sched_step_t  step_o,
  output logic                    busy_o,
  output logic                    reg_enable_o
);

  sched_pkg::sched_state_e                   state_q;
  sched_pkg::sched_state_e                   state_d;
  logic [$clog2(sched_pkg::PIPE_REGS+1)-1:0] wait_q;
  logic                                      wait_last;
  logic                                      first_load_q;
  logic                                      computing_q;
  logic                                      stall;

  // The array freezes in LOAD_W as long as one of its operands is not ready
  assign stall = (state_q == sched_pkg::LOAD_W) &&
                 ((!w_valid_i && !w_done_i) ||
                  (x_full_check_i && !x_flags_i.full) ||
                  (y_check_i && !w_done_i && !z_flags_i.loaded));

  assign wait_last = wait_q == sched_pkg::PIPE_REGS;

  always_comb begin
    state_d = state_q;
    case (state_q)
      sched_pkg::IDLE: begin
        if (start_i)
          state_d = sched_pkg::PRELOAD;
      end
      // X must be full, and Z loaded too when the operation adds Y
      sched_pkg::PRELOAD: begin
        if (x_flags_i.full && (z_flags_i.loaded || !cfg_i.y_required))
          state_d = sched_pkg::LOAD_W;
      end
      sched_pkg::LOAD_W: begin
        if (!stall)
          state_d = sched_pkg::WAIT;
      end
      sched_pkg::WAIT: begin
        if (wait_last && !stall)
          state_d = sched_pkg::LOAD_W;
      end
      default: state_d = sched_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= sched_pkg::IDLE;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
    end else if (clear_i) begin
      state_q      <= sched_pkg::IDLE;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Spaces W loads by the depth of the engine pipeline
      if (!stall && (state_q != sched_pkg::IDLE) && (state_q != sched_pkg::PRELOAD))
        wait_q <= wait_last ? '0 : wait_q + 1'b1;
      if (step_o.start)
        first_load_q <= 1'b1;
      else if (step_o.load_step)
        first_load_q <= 1'b0;
      if (step_o.start)
        computing_q <= 1'b0;
      else if (step_o.pad_setup)
        computing_q <= 1'b1;
    end
  end

  assign step_o.start      = (state_q == sched_pkg::IDLE) && start_i;
  assign step_o.pad_setup  = (state_q == sched_pkg::PRELOAD) && (state_d == sched_pkg::LOAD_W);
  assign step_o.load_step  = (state_q == sched_pkg::LOAD_W) && !stall;
  assign step_o.shift_step = ((state_q == sched_pkg::LOAD_W) || (state_q == sched_pkg::WAIT)) &&
                             !stall;
  assign step_o.first_step = first_load_q && step_o.load_step;
  assign step_o.stall      = stall;

  assign busy_o       = state_q != sched_pkg::IDLE;
  assign reg_enable_o = computing_q && !stall;

endmodule

//--- hdl/sched_pkg.sv
package sched_pkg;

  // Array geometry and engine pipeline
  localparam int unsigned ARRAY_H   = 4;
  localparam int unsigned ARRAY_W   = 4;
  localparam int unsigned TOT_DEPTH = 8;
  localparam int unsigned PIPE_REGS = 3;

  localparam int unsigned ITER_W    = 16;
  localparam int unsigned WB_AW     = 8;
  localparam int unsigned WB_DW     = 32;

  typedef enum logic [1:0] {
    IDLE,
    PRELOAD,
    LOAD_W,
    WAIT
  } sched_state_e;

  // Word addresses of the register block
  typedef enum logic [WB_AW-1:0] {
    REG_CTRL    = 8'h00,
    REG_X_ITERS = 8'h04,
    REG_W_ITERS = 8'h08,
    REG_OP_SEL  = 8'h0C,
    REG_STATUS  = 8'h10
  } sched_reg_e;

  typedef struct packed {
    logic [ITER_W-1:0] x_row_iters;
    logic [ITER_W-1:0] x_col_iters;
    logic [ITER_W-1:0] w_row_iters;
    logic [ITER_W-1:0] w_col_iters;
    logic              y_required;
  } sched_cfg_t;

  // Strobes decoded from the FSM state, shared by all sequencers
  typedef struct packed {
    logic start;
    logic pad_setup;
    logic load_step;
    logic shift_step;
    logic first_step;
    logic stall;
  } sched_step_t;

  typedef struct packed {
    logic full;
    logic empty;
  } x_buf_flags_t;

  typedef struct packed {
    logic empty;
    logic loaded;
  } z_buf_flags_t;

  typedef struct packed {
    logic load;
    logic h_shift;
    logic pad_setup;
    logic rst_w_index;
  } x_buf_ctrl_t;

  typedef struct packed {
    logic load;
    logic shift;
  } w_buf_ctrl_t;

  typedef struct packed {
    logic y_push_enable;
    logic fill;
    logic first_load;
  } z_buf_ctrl_t;

  typedef struct packed {
    logic accumulate;
  } engine_ctrl_t;

endpackage

//--- hdl/w_tile_seq.sv
`timescale 1ns/1ps

module w_tile_seq (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  sched_pkg::sched_cfg_t  cfg_i,
  input  sched_pkg::sched_step_t step_i,
  output sched_pkg::w_buf_ctrl_t w_ctrl_o,
  output logic                   w_col_done_o,
  output logic                   w_done_o
);

  logic [sched_pkg::ITER_W-1:0] rows_q;
  logic [sched_pkg::ITER_W-1:0] cols_q;
  logic [sched_pkg::ITER_W-1:0] mat_q;
  logic                         done_q;
  logic                         cols_en;
  logic                         mat_en;

  // Every unstalled LOAD_W consumes one W row
  assign cols_en = step_i.load_step && (rows_q == cfg_i.w_row_iters - 1'b1);
  assign mat_en  = cols_en && (cols_q == cfg_i.w_col_iters - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
      cols_q <= '0;
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      rows_q <= '0;
      cols_q <= '0;
      mat_q  <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      if (step_i.load_step)
        rows_q <= cols_en ? '0 : rows_q + 1'b1;
      if (cols_en)
        cols_q <= mat_en ? '0 : cols_q + 1'b1;
      if (mat_en)
        mat_q <= mat_q + 1'b1;
      // One full W matrix is streamed for every X row tile
      if (mat_en && (mat_q == cfg_i.x_row_iters - 1'b1))
        done_q <= 1'b1;
    end
  end

  assign w_col_done_o = cols_en && !done_q;
  assign w_done_o     = done_q;

  assign w_ctrl_o.load  = step_i.load_step;
  assign w_ctrl_o.shift = step_i.shift_step;

endmodule

//--- hdl/x_tile_seq.sv
`timescale 1ns/1ps

module x_tile_seq (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  sched_pkg::sched_cfg_t   cfg_i,
  input  sched_pkg::sched_step_t  step_i,
  input  logic                    x_valid_i,
  input  sched_pkg::x_buf_flags_t x_flags_i,
  output sched_pkg::x_buf_ctrl_t  x_ctrl_o,
  output logic                    x_full_check_o
);

  logic [sched_pkg::ITER_W-1:0]         cols_q;
  logic [sched_pkg::ITER_W-1:0]         w_q;
  logic [sched_pkg::ITER_W-1:0]         rows_q;
  logic [$clog2(sched_pkg::ARRAY_H)-1:0] shift_q;
  logic                                 done_q;
  logic                                 reload_q;
  logic                                 empty_full_q;
  logic                                 refill_q;
  logic                                 cols_en;
  logic                                 w_en;
  logic                                 rows_en;
  logic                                 shift_last;
  logic                                 reload_en;
  logic                                 reload_rst;
  logic                                 rst_w_index;

  // Empty is a one-cycle pulse from the buffer, so it counts tiles directly
  assign cols_en = x_flags_i.empty;
  assign w_en    = cols_en && (cols_q == cfg_i.x_col_iters - 1'b1);
  assign rows_en = w_en && (w_q == cfg_i.w_col_iters - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_q <= '0;
      w_q    <= '0;
      rows_q <= '0;
      done_q <= 1'b0;
    end else if (clear_i) begin
      cols_q <= '0;
      w_q    <= '0;
      rows_q <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      if (cols_en)
        cols_q <= w_en ? '0 : cols_q + 1'b1;
      if (w_en)
        w_q <= rows_en ? '0 : w_q + 1'b1;
      if (rows_en)
        rows_q <= rows_q + 1'b1;
      if (rows_en && (rows_q == cfg_i.x_row_iters - 1'b1))
        done_q <= 1'b1;
    end
  end

  assign shift_last = shift_q == sched_pkg::ARRAY_H - 1;

  // An empty that arrives while the buffer still reports full is replayed once full drops
  assign reload_en   = step_i.start || cols_en || (empty_full_q && !x_flags_i.full);
  assign reload_rst  = x_flags_i.full && !reload_en;
  assign rst_w_index = step_i.load_step && shift_last && x_flags_i.full;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q      <= '0;
      reload_q     <= 1'b0;
      empty_full_q <= 1'b0;
      refill_q     <= 1'b0;
    end else if (clear_i) begin
      shift_q      <= '0;
      reload_q     <= 1'b0;
      empty_full_q <= 1'b0;
      refill_q     <= 1'b0;
    end else begin
      if (step_i.load_step)
        shift_q <= shift_last ? '0 : shift_q + 1'b1;
      if (reload_rst)
        reload_q <= 1'b0;
      else if (reload_en)
        reload_q <= 1'b1;
      if (!x_flags_i.full)
        empty_full_q <= 1'b0;
      else if (x_flags_i.empty)
        empty_full_q <= 1'b1;
      if (rst_w_index)
        refill_q <= 1'b0;
      else if (x_flags_i.empty)
        refill_q <= 1'b1;
    end
  end

  // Full is only required at the end of a shift round and after the buffer was drained
  assign x_full_check_o = refill_q && shift_last && !done_q;

  assign x_ctrl_o.load        = reload_q && !reload_rst && x_valid_i;
  assign x_ctrl_o.h_shift     = step_i.load_step;
  assign x_ctrl_o.pad_setup   = step_i.pad_setup;
  assign x_ctrl_o.rst_w_index = rst_w_index;

endmodule

//--- hdl/z_tile_seq.sv
`timescale 1ns/1ps

module z_tile_seq (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  sched_pkg::sched_cfg_t   cfg_i,
  input  sched_pkg::sched_step_t  step_i,
  input  logic                    w_col_done_i,
  input  sched_pkg::z_buf_flags_t z_flags_i,
  output sched_pkg::z_buf_ctrl_t  z_ctrl_o,
  output sched_pkg::engine_ctrl_t engine_o,
  output logic                    y_check_o
);

  logic [sched_pkg::ITER_W-1:0]              y_cols_q;
  logic [sched_pkg::ITER_W-1:0]              y_rows_q;
  logic [$clog2(sched_pkg::PIPE_REGS+1)-1:0] wait_q;
  logic [$clog2(sched_pkg::TOT_DEPTH)-1:0]   avail_q;
  logic [$clog2(sched_pkg::TOT_DEPTH)-1:0]   push_q;
  logic                                      wait_en_q;
  logic                                      avail_en_q;
  logic                                      push_en_q;
  logic                                      pushing_q;
  logic                                      run;
  logic                                      y_cols_last;
  logic                                      wait_clr;
  logic                                      avail_clr;
  logic                                      push_set;
  logic                                      push_clr;

  assign run         = !step_i.stall;
  assign y_cols_last = y_cols_q == cfg_i.w_col_iters - 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      y_cols_q <= '0;
      y_rows_q <= '0;
    end else if (clear_i) begin
      y_cols_q <= '0;
      y_rows_q <= '0;
    end else if (z_flags_i.empty) begin
      y_cols_q <= y_cols_last ? '0 : y_cols_q + 1'b1;
      if (y_cols_last)
        y_rows_q <= (y_rows_q == cfg_i.w_row_iters - 1'b1) ? '0 : y_rows_q + 1'b1;
    end
  end

  // Results of a finished column leave the pipeline after PIPE_REGS cycles
  assign wait_clr  = wait_en_q && run && (wait_q == sched_pkg::PIPE_REGS);
  assign avail_clr = avail_en_q && run && (avail_q == sched_pkg::TOT_DEPTH - 1);
  assign push_clr  = push_en_q && run && (push_q == sched_pkg::TOT_DEPTH - 1);
  // Y rows enter one cycle ahead of the fill so they meet the first Z row
  assign push_set  = (wait_en_q && run && (wait_q == sched_pkg::PIPE_REGS - 1)) ||
                     step_i.first_step;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_en_q  <= 1'b0;
      avail_en_q <= 1'b0;
      push_en_q  <= 1'b0;
      wait_q     <= '0;
      avail_q    <= '0;
      push_q     <= '0;
      pushing_q  <= 1'b0;
    end else if (clear_i) begin
      wait_en_q  <= 1'b0;
      avail_en_q <= 1'b0;
      push_en_q  <= 1'b0;
      wait_q     <= '0;
      avail_q    <= '0;
      push_q     <= '0;
      pushing_q  <= 1'b0;
    end else begin
      // A new window request wins, so back-to-back columns keep the window open
      if (w_col_done_i)
        wait_en_q <= 1'b1;
      else if (wait_clr)
        wait_en_q <= 1'b0;
      if (wait_clr)
        avail_en_q <= 1'b1;
      else if (avail_clr)
        avail_en_q <= 1'b0;
      if (push_set)
        push_en_q <= 1'b1;
      else if (push_clr)
        push_en_q <= 1'b0;
      if (wait_en_q && run)
        wait_q <= wait_clr ? '0 : wait_q + 1'b1;
      if (avail_en_q && run)
        avail_q <= avail_clr ? '0 : avail_q + 1'b1;
      if (push_en_q && run)
        push_q <= push_clr ? '0 : push_q + 1'b1;
      if ((push_en_q && run) || pushing_q)
        pushing_q <= push_en_q;
    end
  end

  assign y_check_o = wait_q == sched_pkg::PIPE_REGS;

  assign z_ctrl_o.y_push_enable = push_en_q && run;
  assign z_ctrl_o.fill          = avail_en_q && run;
  assign z_ctrl_o.first_load    = (y_cols_q == '0) && (y_rows_q == '0);

  // The engine restarts its sums while Y is being pushed in
  assign engine_o.accumulate = !pushing_q;

endmodule

//--- list.f
hdl/sched_pkg.sv
hdl/sched_cfg_regs.sv
hdl/sched_fsm.sv
hdl/x_tile_seq.sv
hdl/w_tile_seq.sv
hdl/z_tile_seq.sv
hdl/matmul_scheduler.sv
verification/tb_matmul_scheduler.sv

//--- run.sh
#!/usr/bin/env bash
# Builds with Verilator and runs; passes only when the testbench prints its pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f list.f \
       --top-module tb_matmul_scheduler -o tb_matmul_scheduler \
  && ./obj_dir/tb_matmul_scheduler | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
  || exit 1

//--- verification/tb_matmul_scheduler.sv
`timescale 1ns/1ps

module tb_matmul_scheduler;

  localparam int unsigned X_ROWS      = 1;
  localparam int unsigned X_COLS      = 1;
  localparam int unsigned W_ROWS      = 4;
  localparam int unsigned W_COLS      = 2;
  localparam int unsigned TOTAL_LOADS = X_ROWS * W_COLS * W_ROWS;
  localparam int unsigned TOTAL_FILLS = X_ROWS * W_COLS * sched_pkg::TOT_DEPTH;
  localparam int unsigned MAX_CYCLES  = 4000;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [sched_pkg::WB_AW-1:0]  wb_adr;
  logic [sched_pkg::WB_DW-1:0]  wb_dat_w;
  logic [sched_pkg::WB_DW-1:0]  wb_dat_r;
  logic                         wb_ack;
  logic                         x_valid;
  logic                         w_valid;
  sched_pkg::x_buf_flags_t      x_flags;
  sched_pkg::z_buf_flags_t      z_flags;
  sched_pkg::x_buf_ctrl_t       x_ctrl;
  sched_pkg::w_buf_ctrl_t       w_ctrl;
  sched_pkg::z_buf_ctrl_t       z_ctrl;
  sched_pkg::engine_ctrl_t      engine;
  logic                         reg_enable;

  integer seed;
  int     cycles;
  int     loads_seen;
  int     fills_seen;
  int     pads_seen;
  int     since_load;
  int     x_loads;
  int     z_delay;
  logic   active;
  logic   monitor_on;

  matmul_scheduler u_matmul_scheduler (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .x_valid_i    (x_valid),
    .w_valid_i    (w_valid),
    .x_flags_i    (x_flags),
    .z_flags_i    (z_flags),
    .x_ctrl_o     (x_ctrl),
    .w_ctrl_o     (w_ctrl),
    .z_ctrl_o     (z_ctrl),
    .engine_o     (engine),
    .reg_enable_o (reg_enable)
  );

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // One classic cycle where ack must rise after one cycle and last exactly one
  task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] data,
                            output logic [31:0] rdata);
    @(posedge clk_i);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= data;
    @(negedge clk_i);
    assert (wb_ack == 1'b0) else report_mismatch("wb_ack_o early", wb_ack, 0);
    @(negedge clk_i);
    assert (wb_ack == 1'b1) else report_mismatch("wb_ack_o", wb_ack, 1);
    rdata = wb_dat_r;
    @(posedge clk_i);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk_i);
    assert (wb_ack == 1'b0) else report_mismatch("wb_ack_o length", wb_ack, 0);
  endtask

  task automatic bus_write(input logic [7:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic read_and_compare(input logic [7:0] adr, input logic [31:0] mask,
                                  input logic [31:0] exp, input string name);
    logic [31:0] got;
    bus_access(1'b0, adr, 32'h0, got);
    assert ((got & mask) == exp) else report_mismatch(name, got & mask, exp);
  endtask

  task automatic expect_silent(input string when);
    logic [9:0] ctrl;
    ctrl = {x_ctrl, w_ctrl, z_ctrl.y_push_enable, z_ctrl.fill, reg_enable, wb_ack};
    assert (ctrl == '0) else report_mismatch(when, ctrl, 0);
    // At rest the engine accumulates and the Y counters sit on the first tile
    assert (engine.accumulate)
      else report_mismatch("engine_o.accumulate", engine.accumulate, 1);
    assert (z_ctrl.first_load)
      else report_mismatch("z_ctrl_o.first_load", z_ctrl.first_load, 1);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
      abort_run("Timeout: the run did not finish within the cycle limit");
  end

  // X reports full after a burst of ARRAY_H loads and Z follows a bit later
  always @(posedge clk_i) begin
    if (x_ctrl.load)
      x_loads <= x_loads + 1;
    if (x_loads >= sched_pkg::ARRAY_H)
      x_flags.full <= 1'b1;
    if (x_flags.full && z_delay < 3)
      z_delay <= z_delay + 1;
    if (z_delay == 3)
      z_flags.loaded <= 1'b1;
    // Random W starvation only during the second half of the stream
    if (loads_seen >= W_ROWS && loads_seen < TOTAL_LOADS)
      w_valid <= ($random(seed) & 3) != 0;
    else
      w_valid <= 1'b1;
  end

  always @(negedge clk_i) begin : monitor
    logic ldw;
    logic done;
    logic stalled;
    logic load_exp;
    logic rst_exp;
    if (monitor_on) begin
      if (active)
        since_load = since_load + 1;
      ldw      = active && (since_load >= sched_pkg::PIPE_REGS + 1);
      done     = loads_seen >= TOTAL_LOADS;
      stalled  = ldw && !w_valid && !done;
      load_exp = ldw && !stalled;
      if (!active) begin
        assert (!w_ctrl.load) else report_mismatch("w_ctrl_o.load", w_ctrl.load, 0);
        assert (!w_ctrl.shift) else report_mismatch("w_ctrl_o.shift", w_ctrl.shift, 0);
        assert (!reg_enable) else report_mismatch("reg_enable_o", reg_enable, 0);
      end else begin
        assert (w_ctrl.load == load_exp)
          else report_mismatch("w_ctrl_o.load", w_ctrl.load, load_exp);
        assert (w_ctrl.shift == !stalled)
          else report_mismatch("w_ctrl_o.shift", w_ctrl.shift, !stalled);
        assert (reg_enable == !stalled)
          else report_mismatch("reg_enable_o", reg_enable, !stalled);
      end
      if (stalled) begin
        assert (!z_ctrl.fill) else report_mismatch("z_ctrl_o.fill", z_ctrl.fill, 0);
        assert (!z_ctrl.y_push_enable)
          else report_mismatch("z_ctrl_o.y_push_enable", z_ctrl.y_push_enable, 0);
      end
      // The first load opens the push window and the engine restarts its sums one cycle later
      if (loads_seen == 1 && since_load == 1) begin
        assert (z_ctrl.y_push_enable)
          else report_mismatch("z_ctrl_o.y_push_enable", z_ctrl.y_push_enable, 1);
      end
      if (loads_seen == 1 && since_load == 2) begin
        assert (!engine.accumulate)
          else report_mismatch("engine_o.accumulate", engine.accumulate, 0);
      end
      assert (x_ctrl.h_shift == load_exp)
        else report_mismatch("x_ctrl_o.h_shift", x_ctrl.h_shift, load_exp);
      if (load_exp)
        loads_seen = loads_seen + 1;
      rst_exp = load_exp && (loads_seen % sched_pkg::ARRAY_H == 0) && x_flags.full;
      assert (x_ctrl.rst_w_index == rst_exp)
        else report_mismatch("x_ctrl_o.rst_w_index", x_ctrl.rst_w_index, rst_exp);
      if (z_ctrl.fill)
        fills_seen = fills_seen + 1;
      if (x_ctrl.pad_setup) begin
        pads_seen = pads_seen + 1;
        assert (pads_seen == 1) else report_mismatch("pad_setup count", pads_seen, 1);
        assert (x_flags.full && z_flags.loaded)
          else abort_run("pad_setup before X full and Z loaded");
        active     = 1'b1;
        since_load = sched_pkg::PIPE_REGS;
      end
      if (load_exp)
        since_load = 0;
    end
  end

  initial begin
    seed       = 32'h18c651e2;
    cycles     = 0;
    loads_seen = 0;
    fills_seen = 0;
    pads_seen  = 0;
    since_load = 0;
    x_loads    = 0;
    z_delay    = 0;
    active     = 1'b0;
    monitor_on = 1'b0;
    rst_ni     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    x_valid    = 1'b1;
    w_valid    = 1'b1;
    x_flags    = '0;
    z_flags    = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    expect_silent("outputs after reset");
    monitor_on = 1'b1;

    bus_write(sched_pkg::REG_X_ITERS, {16'(X_ROWS), 16'(X_COLS)});
    bus_write(sched_pkg::REG_W_ITERS, {16'(W_ROWS), 16'(W_COLS)});
    bus_write(sched_pkg::REG_OP_SEL, 32'h1);
    read_and_compare(sched_pkg::REG_X_ITERS, '1, {16'(X_ROWS), 16'(X_COLS)}, "REG_X_ITERS");
    read_and_compare(sched_pkg::REG_W_ITERS, '1, {16'(W_ROWS), 16'(W_COLS)}, "REG_W_ITERS");
    read_and_compare(sched_pkg::REG_OP_SEL, '1, 32'h1, "REG_OP_SEL");
    read_and_compare(sched_pkg::REG_STATUS, 32'h1, 32'h0, "STATUS busy");

    bus_write(sched_pkg::REG_CTRL, 32'h1);
    wait (loads_seen >= TOTAL_LOADS);
    repeat (2) @(posedge clk_i);
    read_and_compare(sched_pkg::REG_STATUS, 32'h3, 32'h3, "STATUS busy and w_done");

    wait (fills_seen >= TOTAL_FILLS);
    repeat (20) @(negedge clk_i);
    assert (fills_seen == TOTAL_FILLS) else report_mismatch("fill count", fills_seen, TOTAL_FILLS);
    assert (pads_seen == 1) else report_mismatch("pad_setup count", pads_seen, 1);

    monitor_on = 1'b0;
    bus_write(sched_pkg::REG_CTRL, 32'h2);
    read_and_compare(sched_pkg::REG_STATUS, 32'h1, 32'h0, "STATUS busy after clear");
    repeat (8) begin
      @(negedge clk_i);
      expect_silent("outputs after soft clear");
    end

    // A Z empty moves the Y counters off the first tile
    @(posedge clk_i);
    z_flags.empty <= 1'b1;
    @(posedge clk_i);
    z_flags.empty <= 1'b0;
    @(negedge clk_i);
    assert (!z_ctrl.first_load)
      else report_mismatch("z_ctrl_o.first_load", z_ctrl.first_load, 0);

    $display("TB PASSED");
    $finish;
  end

endmodule
